//--- hw/axil_params.svh
`ifndef AXIL_PARAMS_SVH
`define AXIL_PARAMS_SVH

// Bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

// Register block layout
`define REG_COUNT 8
`define REG_BASE 32'h0000_1000
`define REG_ID_VALUE 32'hA11C_0001

`endif

//--- hw/axil_pkg.sv
`default_nettype none

`include "axil_params.svh"

package axil_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    typedef logic [`AXIL_ADDR_W-1:0] addr_t;

    // W channel beat
    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] data;
        logic [`AXIL_STRB_W-1:0] strb;
    } wbeat_t;

endpackage

`default_nettype wire

//--- hw/regmap_pkg.sv
`default_nettype none

`include "axil_params.svh"

package regmap_pkg;

    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // Outcome of an address decode
    typedef enum logic [1:0] {
        ACC_OK        = 2'b00,
        ACC_READ_ONLY = 2'b01,
        ACC_UNMAPPED  = 2'b10
    } access_t;

endpackage

`default_nettype wire

//--- hw/axil_chan_buf.sv
`timescale 1ns/1ns
`default_nettype none

module axil_chan_buf #(
    parameter type payload_t = logic
) (
    input  wire      axi_if,
    input  wire      rst_n,
    input  wire      in_valid,
    output logic     in_ready,
    input  wire      payload_t in_payload,
    input  wire      pop,
    output logic     out_valid,
    output payload_t out_payload
);

    logic full;

    assign in_ready  = ~full;
    assign out_valid = full;

    always_ff @(posedge axi_if) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (pop) begin
            full <= 1'b0;
        end
    end

    // Payload captured on the input handshake
    always_ff @(posedge axi_if) begin
        if (in_valid && in_ready) begin
            out_payload <= in_payload;
        end
    end

    a_pop_when_full: assert property (
        @(posedge axi_if) disable iff (!rst_n) pop |-> full
    );

endmodule

`default_nettype wire

//--- hw/axil_master.sv
`timescale 1ns/1ns
`default_nettype none

`include "axil_params.svh"

module axil_master (
    input  wire                     axi_if,
    input  wire                     rst_n,
    input  wire                     write_req,
    input  wire axil_pkg::addr_t    write_addr,
    input  wire [`AXIL_DATA_W-1:0]  write_data,
    input  wire [`AXIL_STRB_W-1:0]  write_strb,
    output logic                    write_done,
    output axil_pkg::resp_t         write_resp,
    input  wire                     read_req,
    input  wire axil_pkg::addr_t    read_addr,
    output logic                    read_done,
    output logic [`AXIL_DATA_W-1:0] read_data,
    output axil_pkg::resp_t         read_resp,
    output axil_pkg::addr_t         awaddr,
    output logic                    awvalid,
    input  wire                     awready,
    output logic [`AXIL_DATA_W-1:0] wdata,
    output logic [`AXIL_STRB_W-1:0] wstrb,
    output logic                    wvalid,
    input  wire                     wready,
    input  wire axil_pkg::resp_t    bresp,
    input  wire                     bvalid,
    output logic                    bready,
    output axil_pkg::addr_t         araddr,
    output logic                    arvalid,
    input  wire                     arready,
    input  wire [`AXIL_DATA_W-1:0]  rdata,
    input  wire axil_pkg::resp_t    rresp,
    input  wire                     rvalid,
    output logic                    rready
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR_DATA,
        W_RESP
    } wr_state_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } rd_state_t;

    wr_state_t w_state;
    rd_state_t r_state;
    logic      aw_seen;
    logic      w_seen;
    logic      aw_accept;
    logic      w_accept;

    // AW and W may be accepted in either order or together
    assign aw_accept = aw_seen | (awvalid & awready);
    assign w_accept  = w_seen | (wvalid & wready);

    always_ff @(posedge axi_if) begin
        if (!rst_n) begin
            w_state    <= W_IDLE;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            bready     <= 1'b0;
            aw_seen    <= 1'b0;
            w_seen     <= 1'b0;
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            case (w_state)
                W_IDLE: begin
                    if (write_req) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        aw_seen <= 1'b0;
                        w_seen  <= 1'b0;
                        w_state <= W_ADDR_DATA;
                    end
                end
                W_ADDR_DATA: begin
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        aw_seen <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                        w_seen <= 1'b1;
                    end
                    if (aw_accept && w_accept) begin
                        bready  <= 1'b1;
                        w_state <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (bvalid && bready) begin
                        bready     <= 1'b0;
                        write_done <= 1'b1;
                        w_state    <= W_IDLE;
                    end
                end
                default: w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge axi_if) begin
        if (w_state == W_IDLE && write_req) begin
            awaddr <= write_addr;
            wdata  <= write_data;
            wstrb  <= write_strb;
        end
        if (w_state == W_RESP && bvalid && bready) begin
            write_resp <= bresp;
        end
    end

    always_ff @(posedge axi_if) begin
        if (!rst_n) begin
            r_state   <= R_IDLE;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            read_done <= 1'b0;
        end else begin
            read_done <= 1'b0;
            case (r_state)
                R_IDLE: begin
                    if (read_req) begin
                        arvalid <= 1'b1;
                        r_state <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        r_state <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (rvalid && rready) begin
                        rready    <= 1'b0;
                        read_done <= 1'b1;
                        r_state   <= R_IDLE;
                    end
                end
                default: r_state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge axi_if) begin
        if (r_state == R_IDLE && read_req) begin
            araddr <= read_addr;
        end
        if (r_state == R_DATA && rvalid && rready) begin
            read_data <= rdata;
            read_resp <= rresp;
        end
    end

    a_aw_hold: assert property (
        @(posedge axi_if) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr)
    );

    a_ar_hold: assert property (
        @(posedge axi_if) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    // Requests are dropped while a direction is busy
    a_wr_req_idle: assert property (
        @(posedge axi_if) disable iff (!rst_n) write_req |-> w_state == W_IDLE
    );

    a_rd_req_idle: assert property (
        @(posedge axi_if) disable iff (!rst_n) read_req |-> r_state == R_IDLE
    );

endmodule

`default_nettype wire

//--- hw/axil_reg_slave.sv
`timescale 1ns/1ns
`default_nettype none

`include "axil_params.svh"

module axil_reg_slave (
    input  wire                     axi_if,
    input  wire                     rst_n,
    input  wire axil_pkg::addr_t    awaddr,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire [`AXIL_DATA_W-1:0]  wdata,
    input  wire [`AXIL_STRB_W-1:0]  wstrb,
    input  wire                     wvalid,
    output logic                    wready,
    output axil_pkg::resp_t         bresp,
    output logic                    bvalid,
    input  wire                     bready,
    input  wire axil_pkg::addr_t    araddr,
    input  wire                     arvalid,
    output logic                    arready,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output axil_pkg::resp_t         rresp,
    output logic                    rvalid,
    input  wire                     rready
);

    axil_pkg::addr_t      aw_addr;
    axil_pkg::addr_t      ar_addr;
    axil_pkg::wbeat_t     w_in;
    axil_pkg::wbeat_t     w_beat;
    logic                 aw_full;
    logic                 w_full;
    logic                 ar_full;
    logic                 do_write;
    logic                 do_read;
    regmap_pkg::access_t  wr_acc;
    regmap_pkg::access_t  rd_acc;
    regmap_pkg::reg_idx_t wr_idx;
    regmap_pkg::reg_idx_t rd_idx;
    axil_pkg::resp_t      wr_resp;
    logic [`AXIL_DATA_W-1:0] rd_word;

    // Register 0 is the ID constant and has no storage
    logic [`AXIL_DATA_W-1:0] regs [1:`REG_COUNT-1];

    function automatic regmap_pkg::reg_idx_t decode_idx(input axil_pkg::addr_t addr);
        axil_pkg::addr_t offset;
        offset = addr - `REG_BASE;
        return offset[2 +: $bits(regmap_pkg::reg_idx_t)];
    endfunction

    function automatic regmap_pkg::access_t decode_acc(input axil_pkg::addr_t addr);
        axil_pkg::addr_t offset;
        offset = addr - `REG_BASE;
        if (offset >= axil_pkg::addr_t'(`REG_COUNT * 4)) begin
            return regmap_pkg::ACC_UNMAPPED;
        end
        if (decode_idx(addr) == '0) begin
            return regmap_pkg::ACC_READ_ONLY;
        end
        return regmap_pkg::ACC_OK;
    endfunction

    assign w_in.data = wdata;
    assign w_in.strb = wstrb;

    axil_chan_buf #(.payload_t(axil_pkg::addr_t)) aw_buf (
        .axi_if      (axi_if),
        .rst_n       (rst_n),
        .in_valid    (awvalid),
        .in_ready    (awready),
        .in_payload  (awaddr),
        .pop         (do_write),
        .out_valid   (aw_full),
        .out_payload (aw_addr)
    );

    axil_chan_buf #(.payload_t(axil_pkg::wbeat_t)) w_buf (
        .axi_if      (axi_if),
        .rst_n       (rst_n),
        .in_valid    (wvalid),
        .in_ready    (wready),
        .in_payload  (w_in),
        .pop         (do_write),
        .out_valid   (w_full),
        .out_payload (w_beat)
    );

    axil_chan_buf #(.payload_t(axil_pkg::addr_t)) ar_buf (
        .axi_if      (axi_if),
        .rst_n       (rst_n),
        .in_valid    (arvalid),
        .in_ready    (arready),
        .in_payload  (araddr),
        .pop         (do_read),
        .out_valid   (ar_full),
        .out_payload (ar_addr)
    );

    // A pending response holds the buffers full
    assign do_write = aw_full & w_full & ~bvalid;
    assign do_read  = ar_full & ~rvalid;

    assign wr_acc = decode_acc(aw_addr);
    assign wr_idx = decode_idx(aw_addr);
    assign rd_acc = decode_acc(ar_addr);
    assign rd_idx = decode_idx(ar_addr);

    always_comb begin
        case (wr_acc)
            regmap_pkg::ACC_OK:        wr_resp = axil_pkg::OKAY;
            regmap_pkg::ACC_READ_ONLY: wr_resp = axil_pkg::SLVERR;
            default:                   wr_resp = axil_pkg::DECERR;
        endcase
    end

    always_comb begin
        case (rd_acc)
            regmap_pkg::ACC_OK:        rd_word = regs[rd_idx];
            regmap_pkg::ACC_READ_ONLY: rd_word = `REG_ID_VALUE;
            default:                   rd_word = '0;
        endcase
    end

    always_ff @(posedge axi_if) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write && wr_acc == regmap_pkg::ACC_OK) begin
            // Only strobed byte lanes change
            for (int b = 0; b < `AXIL_STRB_W; b++) begin
                if (w_beat.strb[b]) begin
                    regs[wr_idx][8*b +: 8] <= w_beat.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge axi_if) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (do_write) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (do_read) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi_if) begin
        if (do_write) begin
            bresp <= wr_resp;
        end
        if (do_read) begin
            rdata <= rd_word;
            rresp <= (rd_acc == regmap_pkg::ACC_UNMAPPED) ? axil_pkg::DECERR : axil_pkg::OKAY;
        end
    end

    a_b_hold: assert property (
        @(posedge axi_if) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

endmodule

`default_nettype wire

//--- hw/axil_subsys.sv
`timescale 1ns/1ns
`default_nettype none

`include "axil_params.svh"

module axil_subsys (
    input  wire                     axi_if,
    input  wire                     rst_n,
    input  wire                     write_req,
    input  wire axil_pkg::addr_t    write_addr,
    input  wire [`AXIL_DATA_W-1:0]  write_data,
    input  wire [`AXIL_STRB_W-1:0]  write_strb,
    output logic                    write_done,
    output axil_pkg::resp_t         write_resp,
    input  wire                     read_req,
    input  wire axil_pkg::addr_t    read_addr,
    output logic                    read_done,
    output logic [`AXIL_DATA_W-1:0] read_data,
    output axil_pkg::resp_t         read_resp
);

    // AXI4-Lite channels between master and slave
    axil_pkg::addr_t         awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic [`AXIL_STRB_W-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    axil_pkg::resp_t         bresp;
    logic                    bvalid;
    logic                    bready;
    axil_pkg::addr_t         araddr;
    logic                    arvalid;
    logic                    arready;
    logic [`AXIL_DATA_W-1:0] rdata;
    axil_pkg::resp_t         rresp;
    logic                    rvalid;
    logic                    rready;

    axil_master master0 (
        .axi_if     (axi_if),
        .rst_n      (rst_n),
        .write_req  (write_req),
        .write_addr (write_addr),
        .write_data (write_data),
        .write_strb (write_strb),
        .write_done (write_done),
        .write_resp (write_resp),
        .read_req   (read_req),
        .read_addr  (read_addr),
        .read_done  (read_done),
        .read_data  (read_data),
        .read_resp  (read_resp),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    axil_reg_slave slave0 (
        .axi_if  (axi_if),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

`default_nettype wire

//--- dv/tb_axil_subsys.sv
`timescale 1ns/1ns
`default_nettype none

`include "axil_params.svh"

module tb_axil_subsys;

    localparam int RAND_PAIRS = 16;
    localparam int DONE_WAIT  = 20;

    logic                    axi_if;
    logic                    rst_n;
    logic                    write_req;
    logic [`AXIL_ADDR_W-1:0] write_addr;
    logic [`AXIL_DATA_W-1:0] write_data;
    logic [`AXIL_STRB_W-1:0] write_strb;
    logic                    write_done;
    axil_pkg::resp_t         write_resp;
    logic                    read_req;
    logic [`AXIL_ADDR_W-1:0] read_addr;
    logic                    read_done;
    logic [`AXIL_DATA_W-1:0] read_data;
    axil_pkg::resp_t         read_resp;

    // Register model with the ID constant in word 0
    logic [31:0] model [0:`REG_COUNT-1];

    logic [7:0]  vec_op    [$];
    logic [31:0] vec_addr  [$];
    logic [31:0] vec_data  [$];
    logic [3:0]  vec_strb  [$];
    logic [31:0] vec_rdata [$];
    logic [31:0] vec_resp  [$];

    logic [31:0] rng_state = 32'd78724;
    int          errors = 0;
    int          checks = 0;
    int          cycles;
    int          cycle_limit;
    bit          limit_ready = 1'b0;
    int          w_idx;
    int          r_idx;
    logic [31:0] rnd;
    logic [31:0] exp_rd;

    axil_subsys dut0 (
        .axi_if     (axi_if),
        .rst_n      (rst_n),
        .write_req  (write_req),
        .write_addr (write_addr),
        .write_data (write_data),
        .write_strb (write_strb),
        .write_done (write_done),
        .write_resp (write_resp),
        .read_req   (read_req),
        .read_addr  (read_addr),
        .read_done  (read_done),
        .read_data  (read_data),
        .read_resp  (read_resp)
    );

    initial begin
        axi_if = 1'b0;
        forever #4 axi_if = ~axi_if;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Address decode straight from the register map rules
    function automatic regmap_pkg::access_t classify(input logic [31:0] addr);
        if (addr < `REG_BASE || addr >= `REG_BASE + 32'(`REG_COUNT * 4)) begin
            return regmap_pkg::ACC_UNMAPPED;
        end
        if (addr - `REG_BASE < 32'd4) begin
            return regmap_pkg::ACC_READ_ONLY;
        end
        return regmap_pkg::ACC_OK;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr - `REG_BASE) >> 2);
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] expected_write_resp(input logic [31:0] addr);
        case (classify(addr))
            regmap_pkg::ACC_OK:        return 32'(axil_pkg::OKAY);
            regmap_pkg::ACC_READ_ONLY: return 32'(axil_pkg::SLVERR);
            default:                   return 32'(axil_pkg::DECERR);
        endcase
    endfunction

    function automatic logic [31:0] expected_read_resp(input logic [31:0] addr);
        if (classify(addr) == regmap_pkg::ACC_UNMAPPED) begin
            return 32'(axil_pkg::DECERR);
        end
        return 32'(axil_pkg::OKAY);
    endfunction

    function automatic logic [31:0] expected_read_data(input logic [31:0] addr);
        if (classify(addr) == regmap_pkg::ACC_UNMAPPED) begin
            return 32'd0;
        end
        return model[word_index(addr)];
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
        if (classify(addr) == regmap_pkg::ACC_OK) begin
            model[word_index(addr)] = merge_lanes(model[word_index(addr)], data, strb);
        end
    endfunction

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is 0x%08h, expected 0x%08h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] strb;
        logic [31:0] rdata;
        logic [31:0] resp;
        fd = $fopen("dv/axil_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the vector file dv/axil_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, rdata, resp);
                if (n == 6) begin
                    vec_op.push_back(op);
                    vec_addr.push_back(addr);
                    vec_data.push_back(data);
                    vec_strb.push_back(strb[3:0]);
                    vec_rdata.push_back(rdata);
                    vec_resp.push_back(resp);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_gap();
        repeat (int'(next_rand() >> 16) % 4) @(negedge axi_if);
    endtask

    // Drives one or both strobes for a cycle and counts the done pulses
    task automatic run_ops(input bit do_wr, input logic [31:0] w_addr,
                           input logic [31:0] w_data, input logic [3:0] w_strb,
                           input bit do_rd, input logic [31:0] r_addr);
        int wr_seen;
        int rd_seen;
        int waited;
        bit wr_missing;
        bit rd_missing;
        wr_seen = 0;
        rd_seen = 0;
        waited = 0;
        @(negedge axi_if);
        write_req  = do_wr;
        write_addr = w_addr;
        write_data = w_data;
        write_strb = w_strb;
        read_req   = do_rd;
        read_addr  = r_addr;
        while (waited < DONE_WAIT && ((do_wr && wr_seen == 0) || (do_rd && rd_seen == 0))) begin
            @(negedge axi_if);
            write_req = 1'b0;
            read_req  = 1'b0;
            waited++;
            if (write_done) begin
                wr_seen++;
            end
            if (read_done) begin
                rd_seen++;
            end
        end
        wr_missing = do_wr && wr_seen == 0;
        rd_missing = do_rd && rd_seen == 0;
        // A done that repeats or stays high is counted here
        repeat (2) begin
            @(negedge axi_if);
            if (write_done) begin
                wr_seen++;
            end
            if (read_done) begin
                rd_seen++;
            end
        end
        if (wr_missing) begin
            errors++;
            $display("write_done never arrived within %0d cycles at %0t", DONE_WAIT, $time);
        end else begin
            check_val("write_done pulse count", 32'(wr_seen), do_wr ? 32'd1 : 32'd0);
        end
        if (rd_missing) begin
            errors++;
            $display("read_done never arrived within %0d cycles at %0t", DONE_WAIT, $time);
        end else begin
            check_val("read_done pulse count", 32'(rd_seen), do_rd ? 32'd1 : 32'd0);
        end
    endtask

    task automatic run_vector(input int i);
        if (vec_op[i] == "W") begin
            check_val($sformatf("vector %0d response", i), vec_resp[i],
                      expected_write_resp(vec_addr[i]));
            run_ops(1'b1, vec_addr[i], vec_data[i], vec_strb[i], 1'b0, 32'd0);
            model_write(vec_addr[i], vec_data[i], vec_strb[i]);
            check_val("write_resp", 32'(write_resp), vec_resp[i]);
        end else if (vec_op[i] == "R") begin
            check_val($sformatf("vector %0d read data", i), vec_rdata[i],
                      expected_read_data(vec_addr[i]));
            check_val($sformatf("vector %0d response", i), vec_resp[i],
                      expected_read_resp(vec_addr[i]));
            run_ops(1'b0, 32'd0, 32'd0, 4'd0, 1'b1, vec_addr[i]);
            check_val("read_data", read_data, vec_rdata[i]);
            check_val("read_resp", 32'(read_resp), vec_resp[i]);
        end else begin
            errors++;
            $display("Vector %0d has an unknown operation letter", i);
        end
    endtask

    initial begin
        cycles = 0;
        wait (limit_ready);
        while (cycles < cycle_limit) begin
            @(posedge axi_if);
            cycles++;
        end
        $display("Timeout: the run went past %0d cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        write_req  = 1'b0;
        write_addr = '0;
        write_data = '0;
        write_strb = '0;
        read_req   = 1'b0;
        read_addr  = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = 32'd0;
        end
        model[0] = `REG_ID_VALUE;
        load_vectors();
        if (vec_op.size() == 0) begin
            errors++;
            $display("No vectors were loaded");
        end
        cycle_limit = 30 * (vec_op.size() + 2 * RAND_PAIRS) + 200;
        limit_ready = 1'b1;

        repeat (5) @(negedge axi_if);
        rst_n = 1'b1;

        // Quiet bus after reset
        repeat (4) begin
            @(negedge axi_if);
            check_val("write_done", 32'(write_done), 32'd0);
            check_val("read_done", 32'(read_done), 32'd0);
        end

        for (int i = 0; i < vec_op.size(); i++) begin
            idle_gap();
            run_vector(i);
        end

        // Overlapped write and read to different registers
        for (int n = 0; n < RAND_PAIRS; n++) begin
            w_idx = 1 + int'(next_rand() >> 16) % (`REG_COUNT - 1);
            r_idx = int'(next_rand() >> 16) % `REG_COUNT;
            if (r_idx == w_idx) begin
                r_idx = (r_idx + 1) % `REG_COUNT;
            end
            rnd = next_rand();
            exp_rd = model[r_idx];
            idle_gap();
            run_ops(1'b1, `REG_BASE + 32'(w_idx * 4), next_rand(), rnd[19:16],
                    1'b1, `REG_BASE + 32'(r_idx * 4));
            model_write(write_addr, write_data, write_strb);
            check_val("write_resp", 32'(write_resp), 32'(axil_pkg::OKAY));
            check_val("read_data", read_data, exp_rd);
            check_val("read_resp", 32'(read_resp), 32'(axil_pkg::OKAY));
        end

        @(negedge axi_if);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/axil_vectors.txt
# op addr data strb exp_rdata exp_resp, all numbers in hex
# op is W or R; resp 0 OKAY, 2 SLVERR, 3 DECERR; exp_rdata unused for W
R 00001000 00000000 0 a11c0001 0
R 00001004 00000000 0 00000000 0
R 00001008 00000000 0 00000000 0
R 0000100c 00000000 0 00000000 0
R 00001010 00000000 0 00000000 0
R 00001014 00000000 0 00000000 0
R 00001018 00000000 0 00000000 0
R 0000101c 00000000 0 00000000 0
W 00001004 12345678 f 00000000 0
R 00001004 00000000 0 12345678 0
W 00001008 cafef00d f 00000000 0
W 00001008 00bb0011 5 00000000 0
R 00001008 00000000 0 cabbf011 0
W 0000101c ffffffff 8 00000000 0
R 0000101c 00000000 0 ff000000 0
W 00001000 deadbeef f 00000000 2
R 00001000 00000000 0 a11c0001 0
W 00001020 11111111 f 00000000 3
R 00001020 00000000 0 00000000 3
R 00002000 00000000 0 00000000 3
W 00000ffc 22222222 f 00000000 3
R 00001004 00000000 0 12345678 0
W 00001010 a5a5a5a5 3 00000000 0
R 00001010 00000000 0 0000a5a5 0

//--- vlog.f
+incdir+hw
hw/axil_pkg.sv
hw/regmap_pkg.sv
hw/axil_chan_buf.sv
hw/axil_master.sv
hw/axil_reg_slave.sv
hw/axil_subsys.sv
dv/tb_axil_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the AXI4-Lite subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_axil_subsys -o sim_axil
if [ $? -ne 0 ]; then
    echo "Verilator compile step failed"
    exit 1
fi

./obj_dir/sim_axil > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
